// File: filelist.f
common/dcd_pkg.sv
decode/pre_decoder.sv
decode/inst_decoder.sv
decode/dispatch_msg_gen.sv
rtl/gpr_file.sv
rtl/decode_stage_top.sv
dv/decode_stage_assert.sv
dv/tb_decode_stage.sv

// File: Bender.yml
package:
  name: decode_stage

sources:
  - files:
      - common/dcd_pkg.sv
      - decode/pre_decoder.sv
      - decode/inst_decoder.sv
      - decode/dispatch_msg_gen.sv
      - rtl/gpr_file.sv
      - rtl/decode_stage_top.sv
  - target: test
    files:
      - dv/decode_stage_assert.sv
      - dv/tb_decode_stage.sv

// File: dv/tb_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_stage;

	localparam int clk_period = 20;
	localparam int id_w = 4;
	localparam int num_inst = 200;

	typedef struct packed {
		dcd_pkg::dispatch_req_t msg;
		logic [id_w-1:0]        id;
	} exp_t;

	logic                   clk;
	logic                   resetn;
	logic                   sys_reset_req;
	logic                   flush_req;
	dcd_pkg::fetch_res_t    fetch_res;
	logic [id_w-1:0]        fetch_id;
	logic                   fetch_valid;
	logic                   fetch_ready;
	logic                   wr_en;
	logic [4:0]             wr_id;
	logic [31:0]            wr_data;
	dcd_pkg::dispatch_req_t dispatch;
	logic [id_w-1:0]        dispatch_id;
	logic                   dispatch_valid;
	logic                   dispatch_ready;

	logic [31:0]         rng_state = 32'd26575;
	logic [31:0]         gpr_model [32]; // values loaded through the write port
	exp_t                exp_q [$]; // issued but not yet dispatched
	exp_t                want;
	exp_t                next_exp;
	dcd_pkg::fetch_res_t next_fetch;
	logic [31:0]         rnd;
	logic                taken;

	decode_stage_top #(
		.inst_id_width(id_w)
	) u_dut (
		.clk           (clk),
		.resetn        (resetn),
		.sys_reset_req (sys_reset_req),
		.flush_req     (flush_req),
		.fetch_res     (fetch_res),
		.fetch_id      (fetch_id),
		.fetch_valid   (fetch_valid),
		.fetch_ready   (fetch_ready),
		.wr_en         (wr_en),
		.wr_id         (wr_id),
		.wr_data       (wr_data),
		.dispatch      (dispatch),
		.dispatch_id   (dispatch_id),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready)
	);

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	task automatic fail_now();
		$display("TEST FAILED");
		$fatal(1);
	endtask

	task automatic check_field(input string name, input logic [70:0] expv,
		input logic [70:0] actv);
		assert (actv === expv)
		else
		begin
			$display("[ERROR] %0t: %s expected %h, got %h", $time, name, expv, actv);
			fail_now();
		end
	endtask

	// random instruction and the message the stage must produce for it
	task automatic make_instruction(output dcd_pkg::fetch_res_t fr,
		output dcd_pkg::dispatch_req_t m);
		logic [31:0] r;
		logic [2:0]  kind;
		logic [4:0]  rs1;
		logic [4:0]  rs2;
		logic [4:0]  rd;
		logic [11:0] imm12;
		logic [12:0] bofs;
		logic [31:0] imm_i;
		logic [31:0] rs1v;
		logic [31:0] rs2v;
		logic        misaligned;
		logic [2:0]  ls_err;
		r = xorshift32();
		kind = r[2:0];
		rs1 = r[7:3];
		rs2 = r[12:8];
		rd = r[17:13];
		imm12 = r[29:18];
		r = xorshift32();
		fr.pc = {r[31:2], 2'b00};
		fr.prdt_jump = r[0];
		fr.imem_err = (r[3:1] == 3'b000) ? r[5:4] : dcd_pkg::imem_normal; // rare fetch error
		rs1v = gpr_model[rs1];
		rs2v = gpr_model[rs2];
		imm_i = {{20{imm12[11]}}, imm12};
		bofs = {imm12, 1'b0};
		misaligned = ((rs1v + imm_i) & 32'd3) != 32'd0; // word access
		ls_err = dcd_pkg::err_normal;
		m = '0;
		m.pc = fr.pc;
		m.brc_pc_upd_store_din = fr.pc + 32'd4;
		m.rd_vld = 1'b1;
		case (kind)
			3'd0: // addi
			begin
				fr.inst = {imm12, rs1, 3'b000, rd, dcd_pkg::op_imm};
				m.reused.other = {2'b00, fr.prdt_jump, dcd_pkg::alu_add, rs1v, imm_i};
			end
			3'd1: // add
			begin
				fr.inst = {7'b0000000, rs2, rs1, 3'b000, rd, dcd_pkg::op_reg};
				m.reused.other = {2'b00, fr.prdt_jump, dcd_pkg::alu_add, rs1v, rs2v};
			end
			3'd2: // lw
			begin
				fr.inst = {imm12, rs1, 3'b010, rd, dcd_pkg::op_load};
				m.inst_type.load = 1'b1;
				m.reused.ls = {dcd_pkg::ls_word, dcd_pkg::alu_add, rs1v, imm_i};
				if (misaligned)
					ls_err = dcd_pkg::err_ld_unaligned;
			end
			3'd3: // sw
			begin
				fr.inst = {imm12[11:5], rs2, rs1, 3'b010, imm12[4:0], dcd_pkg::op_store};
				m.inst_type.store = 1'b1;
				m.reused.ls = {dcd_pkg::ls_word, dcd_pkg::alu_add, rs1v, imm_i};
				m.brc_pc_upd_store_din = rs2v; // store data
				m.rd_vld = 1'b0;
				if (misaligned)
					ls_err = dcd_pkg::err_st_unaligned;
			end
			3'd4: // csrrw
			begin
				fr.inst = {imm12, rs1, 3'b001, rd, dcd_pkg::op_system};
				m.inst_type.csr_rw = 1'b1;
				m.reused.csr.csr = {imm12, 2'b01, rs1v};
			end
			3'd5: // mul with both operands signed
			begin
				fr.inst = {7'b0000001, rs2, rs1, 3'b000, rd, dcd_pkg::op_reg};
				m.inst_type.mul = 1'b1;
				m.reused.muldiv.muldiv = {rs1v[31], rs1v, rs2v[31], rs2v, 1'b0};
			end
			3'd6: // beq
			begin
				fr.inst = {bofs[12], bofs[10:5], rs2, rs1, 3'b000, bofs[4:1], bofs[11],
					dcd_pkg::op_branch};
				m.inst_type.b = 1'b1;
				m.reused.other = {2'b00, fr.prdt_jump, dcd_pkg::alu_eq, rs1v, rs2v};
				m.rd_vld = 1'b0;
				if (!fr.prdt_jump)
					m.brc_pc_upd_store_din = fr.pc + {{19{bofs[12]}}, bofs};
			end
			default: // floating point opcodes are outside RV32IM
			begin
				r = xorshift32();
				fr.inst = {r[31:7], r[0] ? 7'b0000111 : 7'b1010011};
				m.reused.illegal.inst = fr.inst;
				m.rd_vld = 1'b0;
			end
		endcase
		m.rd_id = fr.inst[11:7];
		if (kind == 3'd7)
			m.err_code = dcd_pkg::err_illegal;
		else if (fr.imem_err == dcd_pkg::imem_unaligned)
			m.err_code = dcd_pkg::err_pc_unaligned;
		else if (fr.imem_err != dcd_pkg::imem_normal)
			m.err_code = dcd_pkg::err_bus_fail;
		else
			m.err_code = ls_err;
	endtask

	initial
	begin
		#((num_inst * 40 + 100) * clk_period);
		$display("timeout: the dispatch queue did not drain in time");
		fail_now();
	end

	// compare every dispatch transfer against the oldest issued instruction
	always @(posedge clk)
	begin
		if (resetn && dispatch_valid && dispatch_ready)
		begin
			if (exp_q.size() == 0)
			begin
				$display("dispatch transfer with no instruction outstanding at %0t", $time);
				fail_now();
			end
			else
			begin
				want = exp_q.pop_front();
				check_field("dispatch_id", want.id, dispatch_id);
				check_field("dispatch.reused", want.msg.reused, dispatch.reused);
				check_field("dispatch.inst_type", want.msg.inst_type, dispatch.inst_type);
				check_field("dispatch.pc", want.msg.pc, dispatch.pc);
				check_field("dispatch.brc_pc_upd_store_din", want.msg.brc_pc_upd_store_din,
					dispatch.brc_pc_upd_store_din);
				check_field("dispatch.rd_id", want.msg.rd_id, dispatch.rd_id);
				check_field("dispatch.rd_vld", want.msg.rd_vld, dispatch.rd_vld);
				check_field("dispatch.err_code", want.msg.err_code, dispatch.err_code);
			end
		end
		if (flush_req || sys_reset_req)
			exp_q.delete(); // held message is dropped
	end

	initial
	begin
		resetn = 1'b1;
		sys_reset_req = 1'b0;
		flush_req = 1'b0;
		fetch_res = '0;
		fetch_id = '0;
		fetch_valid = 1'b0;
		wr_en = 1'b0;
		wr_id = '0;
		wr_data = '0;
		dispatch_ready = 1'b0;
		gpr_model[0] = '0;
		@(posedge clk);
		resetn <= 1'b0;
		repeat (4) @(posedge clk);
		resetn <= 1'b1;
		for (int i = 1; i < 32; i++)
		begin
			@(posedge clk);
			rnd = xorshift32();
			wr_en <= 1'b1;
			wr_id <= i[4:0];
			wr_data <= rnd;
			gpr_model[i] = rnd;
		end
		@(posedge clk);
		wr_en <= 1'b0;
		for (int n = 0; n < num_inst; n++)
		begin
			make_instruction(next_fetch, next_exp.msg);
			next_exp.id = n[id_w-1:0];
			fetch_res <= next_fetch;
			fetch_id <= n[id_w-1:0];
			fetch_valid <= 1'b1;
			taken = 1'b0;
			while (!taken)
			begin
				@(posedge clk);
				taken = fetch_ready;
				rnd = xorshift32();
				dispatch_ready <= (rnd[1:0] != 2'b00); // stall about a quarter of cycles
			end
			exp_q.push_back(next_exp);
			rnd = xorshift32();
			if (rnd[3:0] == 4'd0)
			begin
				fetch_valid <= 1'b0;
				dispatch_ready <= 1'b0;
				if (rnd[4])
					flush_req <= 1'b1;
				else
					sys_reset_req <= 1'b1;
				@(posedge clk);
				flush_req <= 1'b0;
				sys_reset_req <= 1'b0;
			end
		end
		fetch_valid <= 1'b0;
		dispatch_ready <= 1'b1;
		while (exp_q.size() != 0)
			@(posedge clk);
		repeat (2) @(posedge clk);
		if (!dispatch_valid)
		begin
			$display("TEST OK");
			$finish;
		end
		else
		begin
			$display("stage still holds a message after all instructions were dispatched");
			fail_now();
		end
	end

endmodule

`default_nettype wire

// File: dv/decode_stage_assert.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_assert #(
	parameter int inst_id_width = 4
) (
	input logic                     clk,
	input logic                     resetn,
	input logic                     sys_reset_req,
	input logic                     flush_req,
	input logic                     fetch_ready,
	input dcd_pkg::dispatch_req_t   dispatch,
	input logic [inst_id_width-1:0] dispatch_id,
	input logic                     dispatch_valid,
	input logic                     dispatch_ready
);

	// held message must not move while downstream stalls
	a_hold_under_stall: assert property (@(posedge clk) disable iff (!resetn)
		(dispatch_valid && !dispatch_ready && !flush_req && !sys_reset_req) |=>
		(dispatch_valid && $stable(dispatch) && $stable(dispatch_id)))
	else $error("dispatch message changed under back-pressure");

	a_idle_after_reset: assert property (@(posedge clk) !resetn |=> !dispatch_valid)
	else $error("dispatch_valid high after reset");

	a_empty_after_flush: assert property (@(posedge clk) disable iff (!resetn)
		(flush_req || sys_reset_req) |=> !dispatch_valid)
	else $error("dispatch_valid high the cycle after a flush");

	a_no_intake_on_stall: assert property (@(posedge clk) disable iff (!resetn)
		(dispatch_valid && !dispatch_ready) |-> !fetch_ready)
	else $error("fetch_ready high while dispatch is stalled");

endmodule

bind decode_stage_top decode_stage_assert #(
	.inst_id_width(inst_id_width)
) u_assert (
	.clk           (clk),
	.resetn        (resetn),
	.sys_reset_req (sys_reset_req),
	.flush_req     (flush_req),
	.fetch_ready   (fetch_ready),
	.dispatch      (dispatch),
	.dispatch_id   (dispatch_id),
	.dispatch_valid(dispatch_valid),
	.dispatch_ready(dispatch_ready)
);

`default_nettype wire

// File: rtl/decode_stage_top.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage_top #(
	parameter int inst_id_width = 4
) (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     sys_reset_req,
	input  logic                     flush_req,
	input  dcd_pkg::fetch_res_t      fetch_res,
	input  logic [inst_id_width-1:0] fetch_id,
	input  logic                     fetch_valid,
	output logic                     fetch_ready,
	input  logic                     wr_en,
	input  logic [4:0]               wr_id,
	input  logic [31:0]              wr_data,
	output dcd_pkg::dispatch_req_t   dispatch,
	output logic [inst_id_width-1:0] dispatch_id,
	output logic                     dispatch_valid,
	input  logic                     dispatch_ready
);

	dcd_pkg::pre_dcd_t pre_dcd;
	logic [4:0]        rs1_id;
	logic [4:0]        rs2_id;
	logic              rd_req_valid;
	logic              rd_req_ready;
	logic [31:0]       rs1_v;
	logic [31:0]       rs2_v;
	logic              rd_res_valid;

	pre_decoder u_pre_dcd (
		.inst   (fetch_res.inst),
		.pre_dcd(pre_dcd)
	);

	dispatch_msg_gen #(
		.inst_id_width(inst_id_width)
	) u_msg_gen (
		.clk           (clk),
		.resetn        (resetn),
		.sys_reset_req (sys_reset_req),
		.flush_req     (flush_req),
		.fetch_res     (fetch_res),
		.fetch_id      (fetch_id),
		.fetch_valid   (fetch_valid),
		.fetch_ready   (fetch_ready),
		.pre_dcd       (pre_dcd),
		.rs1_id        (rs1_id),
		.rs2_id        (rs2_id),
		.rs1_vld       (), // use flags belong to hazard tracking outside this stage
		.rs2_vld       (),
		.rd_req_valid  (rd_req_valid),
		.rd_req_ready  (rd_req_ready),
		.rs1_v         (rs1_v),
		.rs2_v         (rs2_v),
		.rd_res_valid  (rd_res_valid),
		.rd_res_ready  (),
		.dispatch      (dispatch),
		.dispatch_id   (dispatch_id),
		.dispatch_valid(dispatch_valid),
		.dispatch_ready(dispatch_ready)
	);

	gpr_file u_gpr (
		.clk         (clk),
		.resetn      (resetn),
		.wr_en       (wr_en),
		.wr_id       (wr_id),
		.wr_data     (wr_data),
		.rs1_id      (rs1_id),
		.rs2_id      (rs2_id),
		.rd_req_valid(rd_req_valid),
		.rd_req_ready(rd_req_ready),
		.rs1_v       (rs1_v),
		.rs2_v       (rs2_v),
		.rd_res_valid(rd_res_valid)
	);

endmodule

`default_nettype wire

// File: rtl/gpr_file.sv
`timescale 1ns/100ps
`default_nettype none

module gpr_file (
	input  logic        clk,
	input  logic        resetn,
	input  logic        wr_en,
	input  logic [4:0]  wr_id,
	input  logic [31:0] wr_data,
	input  logic [4:0]  rs1_id,
	input  logic [4:0]  rs2_id,
	input  logic        rd_req_valid,
	output logic        rd_req_ready,
	output logic [31:0] rs1_v,
	output logic [31:0] rs2_v,
	output logic        rd_res_valid
);

	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (wr_en && (wr_id != 5'd0))
			regs[wr_id] <= wr_data; // x0 stays at its reset value
	end

	// combinational read, result in the request cycle
	assign rs1_v = regs[rs1_id];
	assign rs2_v = regs[rs2_id];
	assign rd_req_ready = 1'b1;
	assign rd_res_valid = rd_req_valid;

endmodule

`default_nettype wire

// File: decode/dispatch_msg_gen.sv
`timescale 1ns/100ps
`default_nettype none

module dispatch_msg_gen #(
	parameter int inst_id_width = 4
) (
	input  logic                     clk,
	input  logic                     resetn,
	input  logic                     sys_reset_req,
	input  logic                     flush_req,
	input  dcd_pkg::fetch_res_t      fetch_res,
	input  logic [inst_id_width-1:0] fetch_id,
	input  logic                     fetch_valid,
	output logic                     fetch_ready,
	input  dcd_pkg::pre_dcd_t        pre_dcd,
	output logic [4:0]               rs1_id,
	output logic [4:0]               rs2_id,
	output logic                     rs1_vld,
	output logic                     rs2_vld,
	output logic                     rd_req_valid,
	input  logic                     rd_req_ready,
	input  logic [31:0]              rs1_v,
	input  logic [31:0]              rs2_v,
	input  logic                     rd_res_valid,
	output logic                     rd_res_ready,
	output dcd_pkg::dispatch_req_t   dispatch,
	output logic [inst_id_width-1:0] dispatch_id,
	output logic                     dispatch_valid,
	input  logic                     dispatch_ready
);

	logic                   on_flush_rst;
	logic                   can_load; // register empty or being drained
	logic                   intake;
	logic                   is_ls;
	logic                   is_muldiv;
	dcd_pkg::inst_type_t    inst_type;
	dcd_pkg::alu_op_t       alu_op;
	dcd_pkg::lsu_op_t       lsu_op;
	dcd_pkg::csr_op_t       csr_op;
	dcd_pkg::muldiv_op_t    muldiv_op;
	logic [31:0]            brc_pc_upd;
	logic                   ls_addr_aligned;
	dcd_pkg::dispatch_msg_u nxt_reused;
	logic [2:0]             nxt_err;

	assign on_flush_rst = sys_reset_req | flush_req;
	assign can_load = ~dispatch_valid | dispatch_ready;

	// register read goes out with the fetch result, answer comes back the same cycle
	assign rd_req_valid = fetch_valid & ~on_flush_rst;
	assign fetch_ready = rd_req_ready & rd_res_valid & can_load & ~on_flush_rst;
	assign rd_res_ready = fetch_valid & can_load & ~on_flush_rst;
	assign intake = rd_res_valid & rd_res_ready;

	assign rs1_id = fetch_res.inst[19:15];
	assign rs2_id = fetch_res.inst[24:20];
	assign rs1_vld = pre_dcd.rs1_vld & ~pre_dcd.illegal; // no reads for a NOP
	assign rs2_vld = pre_dcd.rs2_vld & ~pre_dcd.illegal;

	inst_decoder u_dec (
		.inst           (fetch_res.inst),
		.pre_dcd        (pre_dcd),
		.pc             (fetch_res.pc),
		.rs1_v          (rs1_v),
		.rs2_v          (rs2_v),
		.prdt_jump      (fetch_res.prdt_jump),
		.inst_type      (inst_type),
		.alu_op         (alu_op),
		.lsu_op         (lsu_op),
		.csr_op         (csr_op),
		.muldiv_op      (muldiv_op),
		.brc_pc_upd     (brc_pc_upd),
		.ls_addr_aligned(ls_addr_aligned)
	);

	assign is_ls = inst_type.load | inst_type.store;
	assign is_muldiv = inst_type.mul | inst_type.div | inst_type.rem;

	// pick the union member for the class
	always_comb
	begin
		nxt_reused = '0;
		if (pre_dcd.illegal)
			nxt_reused.illegal.inst = fetch_res.inst; // raw word kept for the trap
		else if (is_ls)
		begin
			nxt_reused.ls.lsu = lsu_op;
			nxt_reused.ls.alu = alu_op;
		end
		else if (inst_type.csr_rw)
			nxt_reused.csr.csr = csr_op;
		else if (is_muldiv)
			nxt_reused.muldiv.muldiv = muldiv_op;
		else
		begin
			nxt_reused.other.prdt_jump = fetch_res.prdt_jump;
			nxt_reused.other.alu = alu_op;
		end
	end

	// illegal first, then fetch errors, then misaligned access
	always_comb
	begin
		nxt_err = dcd_pkg::err_normal;
		if (pre_dcd.illegal)
			nxt_err = dcd_pkg::err_illegal;
		else
			case (fetch_res.imem_err)
				dcd_pkg::imem_unaligned: nxt_err = dcd_pkg::err_pc_unaligned;
				dcd_pkg::imem_bus_err: nxt_err = dcd_pkg::err_bus_fail;
				dcd_pkg::imem_timeout: nxt_err = dcd_pkg::err_bus_fail;
				dcd_pkg::imem_normal:
					if (inst_type.load && !ls_addr_aligned)
						nxt_err = dcd_pkg::err_ld_unaligned;
					else if (inst_type.store && !ls_addr_aligned)
						nxt_err = dcd_pkg::err_st_unaligned;
			endcase
	end

	always_ff @(posedge clk)
	begin
		if (intake)
		begin
			dispatch.reused <= nxt_reused;
			dispatch.inst_type <= pre_dcd.illegal ? '0 : inst_type;
			dispatch.pc <= fetch_res.pc;
			dispatch.brc_pc_upd_store_din <= (inst_type.store && !pre_dcd.illegal) ?
				rs2_v : brc_pc_upd;
			dispatch.rd_id <= fetch_res.inst[11:7];
			dispatch.rd_vld <= pre_dcd.rd_vld & ~pre_dcd.illegal;
			dispatch.err_code <= nxt_err;
			dispatch_id <= fetch_id;
		end
	end

	always_ff @(posedge clk or negedge resetn)
	begin
		if (!resetn)
			dispatch_valid <= 1'b0;
		else if (on_flush_rst)
			dispatch_valid <= 1'b0; // drop whatever is held
		else if (can_load)
			dispatch_valid <= intake;
	end

endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
	input  logic [31:0]         inst,
	input  dcd_pkg::pre_dcd_t   pre_dcd,
	input  logic [31:0]         pc,
	input  logic [31:0]         rs1_v,
	input  logic [31:0]         rs2_v,
	input  logic                prdt_jump,
	output dcd_pkg::inst_type_t inst_type,
	output dcd_pkg::alu_op_t    alu_op,
	output dcd_pkg::lsu_op_t    lsu_op,
	output dcd_pkg::csr_op_t    csr_op,
	output dcd_pkg::muldiv_op_t muldiv_op,
	output logic [31:0]         brc_pc_upd,
	output logic                ls_addr_aligned
);

	logic [6:0]  opcode;
	logic [2:0]  funct3;
	logic        alt; // funct7[5], sub and sra
	logic [31:0] imm_i;
	logic [31:0] imm_s;
	logic [31:0] imm_u;
	logic [31:0] ls_addr;
	logic [31:0] jump_tgt;
	logic        is_jump;
	logic        a_signed;
	logic        b_signed;

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign alt = inst[30];
	assign imm_i = {{20{inst[31]}}, inst[31:20]};
	assign imm_s = {{20{inst[31]}}, inst[31:25], inst[11:7]};
	assign imm_u = {inst[31:12], 12'd0};

	assign inst_type = {pre_dcd.is_mret, pre_dcd.is_ecall, pre_dcd.is_b,
		pre_dcd.is_csr_rw, pre_dcd.is_load, pre_dcd.is_store,
		pre_dcd.is_mul, pre_dcd.is_div, pre_dcd.is_rem};

	always_comb
	begin
		alu_op.op_mode = dcd_pkg::alu_add;
		alu_op.op1 = rs1_v;
		alu_op.op2 = rs2_v;
		case (opcode)
			dcd_pkg::op_lui:
			begin
				alu_op.op1 = '0;
				alu_op.op2 = imm_u;
			end
			dcd_pkg::op_auipc:
			begin
				alu_op.op1 = pc;
				alu_op.op2 = imm_u;
			end
			dcd_pkg::op_jal, dcd_pkg::op_jalr:
			begin
				alu_op.op1 = pc; // link address
				alu_op.op2 = 32'd4;
			end
			dcd_pkg::op_branch:
				case (funct3)
					3'b000: alu_op.op_mode = dcd_pkg::alu_eq;
					3'b001: alu_op.op_mode = dcd_pkg::alu_ne;
					3'b100: alu_op.op_mode = dcd_pkg::alu_lt;
					3'b101: alu_op.op_mode = dcd_pkg::alu_ge;
					3'b110: alu_op.op_mode = dcd_pkg::alu_ltu;
					default: alu_op.op_mode = dcd_pkg::alu_geu;
				endcase
			dcd_pkg::op_load:
				alu_op.op2 = imm_i; // address add
			dcd_pkg::op_store:
				alu_op.op2 = imm_s;
			dcd_pkg::op_imm, dcd_pkg::op_reg:
			begin
				if (opcode == dcd_pkg::op_imm)
					alu_op.op2 = imm_i;
				case (funct3)
					3'b000: alu_op.op_mode = (alt && (opcode == dcd_pkg::op_reg)) ?
						dcd_pkg::alu_sub : dcd_pkg::alu_add;
					3'b001: alu_op.op_mode = dcd_pkg::alu_sll;
					3'b010: alu_op.op_mode = dcd_pkg::alu_slt;
					3'b011: alu_op.op_mode = dcd_pkg::alu_sltu;
					3'b100: alu_op.op_mode = dcd_pkg::alu_xor;
					3'b101: alu_op.op_mode = alt ? dcd_pkg::alu_sra : dcd_pkg::alu_srl;
					3'b110: alu_op.op_mode = dcd_pkg::alu_or;
					default: alu_op.op_mode = dcd_pkg::alu_and;
				endcase
			end
			default: ;
		endcase
	end

	// load/store width and address alignment
	assign lsu_op.ls_type = funct3;
	assign ls_addr = rs1_v + (pre_dcd.is_store ? imm_s : imm_i);

	always_comb
	begin
		case (lsu_op.ls_type)
			dcd_pkg::ls_word: ls_addr_aligned = (ls_addr[1:0] == 2'b00);
			dcd_pkg::ls_half, dcd_pkg::ls_half_u: ls_addr_aligned = ~ls_addr[0];
			dcd_pkg::ls_byte, dcd_pkg::ls_byte_u: ls_addr_aligned = 1'b1;
			default: ls_addr_aligned = 1'b0;
		endcase
	end

	assign csr_op.csr_addr = pre_dcd.csr_addr;
	assign csr_op.upd_type = funct3[1:0];
	assign csr_op.upd_mask = funct3[2] ? {27'd0, inst[19:15]} : rs1_v; // zimm forms

	// mulhu/divu/remu take rs1 unsigned, mulhsu also rs2
	assign a_signed = ~(funct3[0] & (funct3[1] | funct3[2]));
	assign b_signed = funct3[2] ? ~funct3[0] : ~funct3[1];
	assign muldiv_op.op_a = {a_signed & rs1_v[31], rs1_v};
	assign muldiv_op.op_b = {b_signed & rs2_v[31], rs2_v};
	assign muldiv_op.res_sel = pre_dcd.is_mul & (funct3[1:0] != 2'b00);

	assign is_jump = pre_dcd.is_jal | pre_dcd.is_jalr | pre_dcd.is_b;
	assign jump_tgt = pre_dcd.is_jalr ? ((rs1_v + imm_i) & ~32'd1) :
		pc + {{11{pre_dcd.jump_ofs_imm[20]}}, pre_dcd.jump_ofs_imm};
	// fetch went on to pc+4, correction is the target
	assign brc_pc_upd = (is_jump && !prdt_jump) ? jump_tgt : pc + 32'd4;

endmodule

`default_nettype wire

// File: decode/pre_decoder.sv
`timescale 1ns/100ps
`default_nettype none

module pre_decoder (
	input  logic [31:0]       inst,
	output dcd_pkg::pre_dcd_t pre_dcd
);

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	logic       is_muldiv;
	logic       op_ok; // funct fields valid for this opcode

	assign opcode = inst[6:0];
	assign funct3 = inst[14:12];
	assign funct7 = inst[31:25];
	assign is_muldiv = (opcode == dcd_pkg::op_reg) && (funct7 == 7'b0000001);

	always_comb
	begin
		pre_dcd = '0;
		op_ok = 1'b1;
		case (opcode)
			dcd_pkg::op_lui, dcd_pkg::op_auipc:
				pre_dcd.rd_vld = 1'b1;
			dcd_pkg::op_jal:
			begin
				pre_dcd.is_jal = 1'b1;
				pre_dcd.rd_vld = 1'b1;
				pre_dcd.jump_ofs_imm = {inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
			end
			dcd_pkg::op_jalr:
			begin
				pre_dcd.is_jalr = 1'b1;
				pre_dcd.rd_vld = 1'b1;
				pre_dcd.rs1_vld = 1'b1;
				op_ok = (funct3 == 3'b000);
			end
			dcd_pkg::op_branch:
			begin
				pre_dcd.is_b = 1'b1;
				pre_dcd.rs1_vld = 1'b1;
				pre_dcd.rs2_vld = 1'b1;
				// 13 bit offset widened to the 21 bit field
				pre_dcd.jump_ofs_imm = {{8{inst[31]}}, inst[31], inst[7], inst[30:25],
					inst[11:8], 1'b0};
				op_ok = (funct3[2:1] != 2'b01);
			end
			dcd_pkg::op_load:
			begin
				pre_dcd.is_load = 1'b1;
				pre_dcd.rd_vld = 1'b1;
				pre_dcd.rs1_vld = 1'b1;
				op_ok = (funct3 != 3'b011) && (funct3[2:1] != 2'b11);
			end
			dcd_pkg::op_store:
			begin
				pre_dcd.is_store = 1'b1;
				pre_dcd.rs1_vld = 1'b1;
				pre_dcd.rs2_vld = 1'b1;
				op_ok = (funct3 < 3'b011);
			end
			dcd_pkg::op_imm:
			begin
				pre_dcd.rd_vld = 1'b1;
				pre_dcd.rs1_vld = 1'b1;
				if (funct3 == 3'b001)
					op_ok = (funct7 == 7'b0000000); // slli
				else if (funct3 == 3'b101)
					op_ok = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
			end
			dcd_pkg::op_reg:
			begin
				pre_dcd.rd_vld = 1'b1;
				pre_dcd.rs1_vld = 1'b1;
				pre_dcd.rs2_vld = 1'b1;
				pre_dcd.is_mul = is_muldiv & ~funct3[2];
				pre_dcd.is_div = is_muldiv & funct3[2] & ~funct3[1];
				pre_dcd.is_rem = is_muldiv & funct3[2] & funct3[1];
				op_ok = is_muldiv || (funct7 == 7'b0000000) ||
					((funct7 == 7'b0100000) && ((funct3 == 3'b000) || (funct3 == 3'b101)));
			end
			dcd_pkg::op_fence:
				op_ok = 1'b1; // ordering only
			dcd_pkg::op_system:
			begin
				if (funct3 == 3'b000)
				begin
					pre_dcd.is_ecall = (inst == 32'h0000_0073);
					pre_dcd.is_mret = (inst == 32'h3020_0073);
					op_ok = pre_dcd.is_ecall | pre_dcd.is_mret;
				end
				else
				begin
					pre_dcd.is_csr_rw = 1'b1;
					pre_dcd.rd_vld = 1'b1;
					pre_dcd.rs1_vld = ~funct3[2]; // immediate forms use zimm
					op_ok = (funct3 != 3'b100);
				end
			end
			default:
				op_ok = 1'b0;
		endcase
		pre_dcd.csr_addr = inst[31:20];
		pre_dcd.illegal = ~op_ok;
	end

endmodule

`default_nettype wire

// File: common/dcd_pkg.sv
`default_nettype none

package dcd_pkg;

	// major opcodes of RV32IM and the system ops
	localparam logic [6:0] op_lui = 7'b0110111;
	localparam logic [6:0] op_auipc = 7'b0010111;
	localparam logic [6:0] op_jal = 7'b1101111;
	localparam logic [6:0] op_jalr = 7'b1100111;
	localparam logic [6:0] op_branch = 7'b1100011;
	localparam logic [6:0] op_load = 7'b0000011;
	localparam logic [6:0] op_store = 7'b0100011;
	localparam logic [6:0] op_imm = 7'b0010011;
	localparam logic [6:0] op_reg = 7'b0110011;
	localparam logic [6:0] op_fence = 7'b0001111;
	localparam logic [6:0] op_system = 7'b1110011;

	// error code carried with each dispatched instruction
	localparam logic [2:0] err_normal = 3'b000;
	localparam logic [2:0] err_illegal = 3'b001;
	localparam logic [2:0] err_pc_unaligned = 3'b010;
	localparam logic [2:0] err_bus_fail = 3'b011;
	localparam logic [2:0] err_ld_unaligned = 3'b110;
	localparam logic [2:0] err_st_unaligned = 3'b111;

	// instruction memory response
	localparam logic [1:0] imem_normal = 2'b00;
	localparam logic [1:0] imem_unaligned = 2'b01;
	localparam logic [1:0] imem_bus_err = 2'b10;
	localparam logic [1:0] imem_timeout = 2'b11;

	// load/store width, same as funct3
	localparam logic [2:0] ls_byte = 3'b000;
	localparam logic [2:0] ls_half = 3'b001;
	localparam logic [2:0] ls_word = 3'b010;
	localparam logic [2:0] ls_byte_u = 3'b100;
	localparam logic [2:0] ls_half_u = 3'b101;

	// alu operation modes
	localparam logic [3:0] alu_add = 4'd0;
	localparam logic [3:0] alu_sub = 4'd1;
	localparam logic [3:0] alu_sll = 4'd2;
	localparam logic [3:0] alu_slt = 4'd3;
	localparam logic [3:0] alu_sltu = 4'd4;
	localparam logic [3:0] alu_xor = 4'd5;
	localparam logic [3:0] alu_srl = 4'd6;
	localparam logic [3:0] alu_sra = 4'd7;
	localparam logic [3:0] alu_or = 4'd8;
	localparam logic [3:0] alu_and = 4'd9;
	localparam logic [3:0] alu_eq = 4'd10; // branch compares
	localparam logic [3:0] alu_ne = 4'd11;
	localparam logic [3:0] alu_lt = 4'd12;
	localparam logic [3:0] alu_ge = 4'd13;
	localparam logic [3:0] alu_ltu = 4'd14;
	localparam logic [3:0] alu_geu = 4'd15;

	typedef struct packed {
		logic [31:0] pc;
		logic [31:0] inst;
		logic        prdt_jump;
		logic [1:0]  imem_err;
	} fetch_res_t;

	typedef struct packed {
		logic [15:0] pad;
		logic        illegal;
		logic [11:0] csr_addr;
		logic        rs1_vld;
		logic        rs2_vld;
		logic        rd_vld;
		logic [20:0] jump_ofs_imm; // jal or branch offset
		logic        is_mret;
		logic        is_ecall;
		logic        is_b;
		logic        is_jal;
		logic        is_jalr;
		logic        is_csr_rw;
		logic        is_load;
		logic        is_store;
		logic        is_mul;
		logic        is_div;
		logic        is_rem;
	} pre_dcd_t;

	typedef struct packed {
		logic mret;
		logic ecall;
		logic b;
		logic csr_rw;
		logic load;
		logic store;
		logic mul;
		logic div;
		logic rem;
	} inst_type_t;

	typedef struct packed {
		logic [3:0]  op_mode;
		logic [31:0] op1;
		logic [31:0] op2;
	} alu_op_t;

	typedef struct packed {
		logic [2:0] ls_type;
	} lsu_op_t;

	typedef struct packed {
		logic [11:0] csr_addr;
		logic [1:0]  upd_type; // 01 write, 10 set, 11 clear
		logic [31:0] upd_mask;
	} csr_op_t;

	typedef struct packed {
		logic [32:0] op_a;
		logic [32:0] op_b;
		logic        res_sel; // high word of the product
	} muldiv_op_t;

	// one 71 bit word, read according to the instruction class
	typedef union packed {
		struct packed {
			lsu_op_t lsu;
			alu_op_t alu;
		} ls;
		struct packed {
			logic [24:0] pad;
			csr_op_t     csr;
		} csr;
		struct packed {
			logic [3:0] pad;
			muldiv_op_t muldiv;
		} muldiv;
		struct packed {
			logic [38:0] pad;
			logic [31:0] inst;
		} illegal;
		struct packed {
			logic [1:0] pad;
			logic       prdt_jump;
			alu_op_t    alu;
		} other;
	} dispatch_msg_u;

	typedef struct packed {
		dispatch_msg_u reused;
		inst_type_t    inst_type;
		logic [31:0]   pc;
		logic [31:0]   brc_pc_upd_store_din;
		logic [4:0]    rd_id;
		logic          rd_vld;
		logic [2:0]    err_code;
	} dispatch_req_t;

endpackage

`default_nettype wire
